// File: common/datapath_defines.svh
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// Widths and sizes
`define DATA_W    8
`define ADDR_W    8
`define IR_W      16
`define MEM_DEPTH 256
`define RF_REGS   8
`define ARF_REGS  4

// Register function codes
`define REG_CLR  2'd0
`define REG_LOAD 2'd1
`define REG_DEC  2'd2
`define REG_INC  2'd3

////////////////////
// ALU operation codes
////////////////////
`define ALU_OP_PASS_A 4'd0
`define ALU_OP_PASS_B 4'd1
`define ALU_OP_NOT_A  4'd2
`define ALU_OP_NOT_B  4'd3
`define ALU_OP_ADD    4'd4
`define ALU_OP_SUB    4'd5
`define ALU_OP_CMP    4'd6
`define ALU_OP_AND    4'd7
`define ALU_OP_OR     4'd8
`define ALU_OP_NAND   4'd9
`define ALU_OP_XOR    4'd10
`define ALU_OP_LSL    4'd11
`define ALU_OP_LSR    4'd12
`define ALU_OP_ASL    4'd13
`define ALU_OP_ASR    4'd14
`define ALU_OP_CSR    4'd15

`endif

// File: common/datapath_pkg.sv
`default_nettype none

package datapath_pkg;

    `include "datapath_defines.svh"

    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`IR_W-1:0]   ir_t;
    typedef logic [1:0]         reg_fun_t;
    typedef logic [3:0]         alu_op_t;

    // Status register layout
    typedef struct packed {
        logic z;
        logic c;
        logic n;
        logic v;
    } flags_t;

    ////////////////////
    // Control bundles
    ////////////////////

    // Enable bits 0..3 are R1..R4, bits 4..7 are T1..T4
    typedef struct packed {
        logic [$clog2(`RF_REGS)-1:0] out_a_sel;
        logic [$clog2(`RF_REGS)-1:0] out_b_sel;
        reg_fun_t                    fun;
        logic [`RF_REGS-1:0]         enable;
    } rf_ctrl_t;

    // Enable bits 0..3 are AR, SP, PCPast, PC
    typedef struct packed {
        logic [$clog2(`ARF_REGS)-1:0] out_a_sel;
        logic [$clog2(`ARF_REGS)-1:0] out_b_sel;
        reg_fun_t                     fun;
        logic [`ARF_REGS-1:0]         enable;
    } arf_ctrl_t;

    typedef struct packed {
        logic     enable;
        logic     lh;
        reg_fun_t fun;
    } ir_ctrl_t;

    // Chip select is active low and wr high writes
    typedef struct packed {
        logic wr;
        logic cs;
    } mem_ctrl_t;

    typedef struct packed {
        logic [1:0] a_sel;
        logic [1:0] b_sel;
        logic       c_sel;
    } mux_ctrl_t;

    typedef struct packed {
        rf_ctrl_t  rf;
        arf_ctrl_t arf;
        alu_op_t   alu_op;
        ir_ctrl_t  ir;
        mux_ctrl_t mux;
        mem_ctrl_t mem;
    } datapath_ctrl_t;

endpackage

`default_nettype wire

// File: register_bank/function_register.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_defines.svh"

module function_register
    import datapath_pkg::*;
#(
    parameter int width = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             enable,
    input  reg_fun_t         fun,
    input  logic [width-1:0] load_value,
    output logic [width-1:0] value
);

    // Increment and decrement wrap around at the ends
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value <= '0;
        end else if (enable) begin
            case (fun)
                `REG_CLR:  value <= '0;
                `REG_LOAD: value <= load_value;
                `REG_DEC:  value <= value - 1'b1;
                default:   value <= value + 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: register_bank/register_bank.sv
`timescale 1ns/1ns
`default_nettype none

module register_bank
    import datapath_pkg::*;
#(
    parameter int reg_count = 8,
    localparam int sel_w = $clog2(reg_count)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  reg_fun_t             fun,
    input  logic [reg_count-1:0] enable,
    input  data_t                load_value,
    input  logic [sel_w-1:0]     out_a_sel,
    input  logic [sel_w-1:0]     out_b_sel,
    output data_t                out_a,
    output data_t                out_b
);

    data_t regs [reg_count];

    ////////////////////
    // Storage
    ////////////////////

    // Shared data and function with one enable bit per register
    for (genvar i = 0; i < reg_count; i++) begin : g_reg
        function_register #(
            .width($bits(data_t))
        ) u_reg (
            .clk       (clk),
            .rst_n     (rst_n),
            .enable    (enable[i]),
            .fun       (fun),
            .load_value(load_value),
            .value     (regs[i])
        );
    end

    ////////////////////
    // Read ports
    ////////////////////

    // Select value is the register index
    always_comb begin
        out_a = regs[out_a_sel];
    end

    always_comb begin
        out_b = regs[out_b_sel];
    end

endmodule

`default_nettype wire

// File: src/instruction_register.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_defines.svh"

module instruction_register
    import datapath_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  ir_ctrl_t ctrl,
    input  data_t    load_byte,
    output ir_t      ir_out
);

    ir_t load_word;

    // lh picks the half that takes the new byte, the other half is fed back
    always_comb begin
        if (ctrl.lh) begin
            load_word = {load_byte, ir_out[`DATA_W-1:0]};
        end else begin
            load_word = {ir_out[`IR_W-1:`DATA_W], load_byte};
        end
    end

    // Clear, inc and dec see the whole word
    function_register #(
        .width(`IR_W)
    ) u_ir_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (ctrl.enable),
        .fun       (ctrl.fun),
        .load_value(load_word),
        .value     (ir_out)
    );

endmodule

`default_nettype wire

// File: src/data_memory.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_defines.svh"

module data_memory
    import datapath_pkg::*;
(
    input  logic      clk,
    input  mem_ctrl_t ctrl,
    input  addr_t     addr,
    input  data_t     write_data,
    output data_t     read_data
);

    data_t mem [`MEM_DEPTH];

    // Zero when not selected or when writing
    assign read_data = (!ctrl.cs && !ctrl.wr) ? mem[addr] : '0;

    always_ff @(posedge clk) begin
        if (!ctrl.cs && ctrl.wr) begin
            mem[addr] <= write_data;
        end
    end

endmodule

`default_nettype wire

// File: alu/alu_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_defines.svh"

module alu_core
    import datapath_pkg::*;
(
    input  data_t   a,
    input  data_t   b,
    input  alu_op_t op,
    input  logic    carry,
    output data_t   result,
    output flags_t  next_flags
);

    localparam int msb = `DATA_W - 1;

    data_t             add_b;
    logic              add_cin;
    logic [`DATA_W:0]  sum;
    logic              add_ovf;

    ////////////////////
    // Shared adder
    ////////////////////

    // SUB and CMP use a + ~b + 1
    assign add_b   = (op == `ALU_OP_ADD) ? b : ~b;
    assign add_cin = (op != `ALU_OP_ADD);
    assign sum     = {1'b0, a} + {1'b0, add_b} + {{`DATA_W{1'b0}}, add_cin};

    // Same operand signs, different result sign
    assign add_ovf = (a[msb] == add_b[msb]) && (sum[msb] != a[msb]);

    always_comb begin
        case (op)
            `ALU_OP_PASS_A: result = a;
            `ALU_OP_PASS_B: result = b;
            `ALU_OP_NOT_A:  result = ~a;
            `ALU_OP_NOT_B:  result = ~b;
            `ALU_OP_ADD:    result = sum[msb:0];
            `ALU_OP_SUB:    result = sum[msb:0];
            `ALU_OP_CMP:    result = ($signed(a) > $signed(b)) ? a : '0;
            `ALU_OP_AND:    result = a & b;
            `ALU_OP_OR:     result = a | b;
            `ALU_OP_NAND:   result = ~(a & b);
            `ALU_OP_XOR:    result = a ^ b;
            `ALU_OP_LSL:    result = {a[msb-1:0], 1'b0};
            `ALU_OP_LSR:    result = {1'b0, a[msb:1]};
            `ALU_OP_ASL:    result = {a[msb-1:0], 1'b0};
            `ALU_OP_ASR:    result = {a[msb], a[msb:1]};
            default:        result = {carry, a[msb:1]};   // CSR through carry
        endcase
    end

    ////////////////////
    // Candidate flags
    ////////////////////

    // Only meaningful where alu_flags enables the update
    always_comb begin
        next_flags.z = (result == '0);
        next_flags.n = result[msb];
        next_flags.c = 1'b0;
        next_flags.v = 1'b0;
        case (op)
            `ALU_OP_ADD, `ALU_OP_SUB, `ALU_OP_CMP: begin
                next_flags.c = sum[`DATA_W];
                next_flags.v = add_ovf;
            end
            `ALU_OP_LSL: next_flags.c = a[msb];
            `ALU_OP_LSR, `ALU_OP_CSR: next_flags.c = a[0];
            `ALU_OP_ASL: next_flags.v = a[msb] ^ a[msb-1];
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: alu/alu_flags.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_defines.svh"

module alu_flags
    import datapath_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  alu_op_t op,
    input  flags_t  next_flags,
    output flags_t  flags
);

    logic n_upd;
    logic c_upd;
    logic v_upd;

    ////////////////////
    // Update enables
    ////////////////////

    // ASR keeps the sign flag
    assign n_upd = (op != `ALU_OP_ASR);

    always_comb begin
        case (op)
            `ALU_OP_ADD, `ALU_OP_SUB, `ALU_OP_CMP,
            `ALU_OP_LSL, `ALU_OP_LSR, `ALU_OP_CSR: c_upd = 1'b1;
            default:                               c_upd = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            `ALU_OP_ADD, `ALU_OP_SUB, `ALU_OP_CMP, `ALU_OP_ASL: v_upd = 1'b1;
            default:                                            v_upd = 1'b0;
        endcase
    end

    ////////////////////
    // Status register
    ////////////////////

    // Z follows every result
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else begin
            flags.z <= next_flags.z;
            if (n_upd) begin
                flags.n <= next_flags.n;
            end
            if (c_upd) begin
                flags.c <= next_flags.c;
            end
            if (v_upd) begin
                flags.v <= next_flags.v;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/datapath_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_defines.svh"

module datapath_top
    import datapath_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  datapath_ctrl_t ctrl,
    output data_t          alu_out,
    output flags_t         alu_flags,
    output ir_t            ir_out
);

    data_t  mem_data;
    data_t  rf_a;
    data_t  rf_b;
    data_t  arf_a;
    addr_t  mem_addr;
    data_t  mux_a;
    data_t  mux_b;
    data_t  mux_c;
    flags_t next_flags;

    // Mux A and mux B pick from the same four sources
    function automatic data_t pick_source(input logic [1:0] sel, input data_t from_alu,
                                          input data_t from_mem, input data_t from_ir,
                                          input data_t from_arf);
        case (sel)
            2'd0:    return from_alu;
            2'd1:    return from_mem;
            2'd2:    return from_ir;
            default: return from_arf;
        endcase
    endfunction

    assign mux_a = pick_source(ctrl.mux.a_sel, alu_out, mem_data, ir_out[`DATA_W-1:0], arf_a);
    assign mux_b = pick_source(ctrl.mux.b_sel, alu_out, mem_data, ir_out[`DATA_W-1:0], arf_a);
    assign mux_c = ctrl.mux.c_sel ? arf_a : rf_a;

    ////////////////////
    // Register banks
    ////////////////////

    register_bank #(.reg_count(`RF_REGS)) u_rf (
        .clk(clk), .rst_n(rst_n), .fun(ctrl.rf.fun), .enable(ctrl.rf.enable),
        .load_value(mux_a), .out_a_sel(ctrl.rf.out_a_sel), .out_b_sel(ctrl.rf.out_b_sel),
        .out_a(rf_a), .out_b(rf_b)
    );

    // Port B is the memory address
    register_bank #(.reg_count(`ARF_REGS)) u_arf (
        .clk(clk), .rst_n(rst_n), .fun(ctrl.arf.fun), .enable(ctrl.arf.enable),
        .load_value(mux_b), .out_a_sel(ctrl.arf.out_a_sel), .out_b_sel(ctrl.arf.out_b_sel),
        .out_a(arf_a), .out_b(mem_addr)
    );

    instruction_register u_ir (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl.ir), .load_byte(mem_data), .ir_out(ir_out)
    );

    data_memory u_mem (
        .clk(clk), .ctrl(ctrl.mem), .addr(mem_addr), .write_data(alu_out), .read_data(mem_data)
    );

    ////////////////////
    // ALU and status
    ////////////////////

    alu_core u_alu (
        .a(mux_c), .b(rf_b), .op(ctrl.alu_op), .carry(alu_flags.c),
        .result(alu_out), .next_flags(next_flags)
    );

    alu_flags u_alu_flags (
        .clk(clk), .rst_n(rst_n), .op(ctrl.alu_op), .next_flags(next_flags), .flags(alu_flags)
    );

endmodule

`default_nettype wire

// File: verification/datapath_props.sv
`timescale 1ns/1ns
`default_nettype none

module datapath_props
    import datapath_pkg::*;
(
    input logic           clk,
    input logic           rst_n,
    input datapath_ctrl_t ctrl,
    input data_t          alu_out,
    input flags_t         alu_flags,
    input ir_t            ir_out
);

    logic past_valid = 1'b0;
    int   fail_count = 0;

    always @(posedge clk) begin
        past_valid <= 1'b1;
    end

    // Status register comes out of reset cleared
    assert property (@(posedge clk) past_valid && !$past(rst_n) |-> alu_flags == '0)
        else begin
            fail_count++;
            $error("flags not cleared in the cycle after reset");
        end

    // Z tracks the previous result
    assert property (@(posedge clk) disable iff (!rst_n)
        past_valid && $past(rst_n) |-> alu_flags.z == ($past(alu_out) == '0))
        else begin
            fail_count++;
            $error("Z flag does not match the previous ALU result");
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        past_valid && $past(rst_n && !ctrl.ir.enable) |-> $stable(ir_out))
        else begin
            fail_count++;
            $error("instruction register changed while disabled");
        end

endmodule

bind datapath_top datapath_props u_datapath_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .alu_out  (alu_out),
    .alu_flags(alu_flags),
    .ir_out   (ir_out)
);

`default_nettype wire

// File: verification/datapath_tb.sv
`timescale 1ns/1ns
`default_nettype none

module datapath_tb
    import datapath_pkg::*;
();

    localparam string vector_file = "verification/datapath_input.txt";
    localparam int clk_period = 4;

    logic           clk;
    logic           rst_n;
    datapath_ctrl_t ctrl;
    data_t          alu_out;
    flags_t         alu_flags;
    ir_t            ir_out;

    // One entry per vector line
    int             test_q[$];
    datapath_ctrl_t ctrl_q[$];
    data_t          alu_exp_q[$];
    flags_t         flags_exp_q[$];
    ir_t            ir_exp_q[$];
    logic [2:0]     mask_q[$];

    int   check_count;
    int   error_count;
    logic vectors_loaded;

    datapath_top u_datapath_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .alu_out  (alu_out),
        .alu_flags(alu_flags),
        .ir_out   (ir_out)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic compare_value(input string what, input logic [15:0] got,
                                 input logic [15:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    ////////////////////
    // Vector file
    ////////////////////

    task automatic load_vectors();
        int                            fd;
        int                            fields;
        string                         line;
        int                            tnum;
        logic [$bits(datapath_ctrl_t)-1:0] word;
        logic [7:0]                    alu_exp;
        logic [3:0]                    flags_exp;
        logic [15:0]                   ir_exp;
        logic [2:0]                    mask;
        fd = $fopen(vector_file, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", vector_file);
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%d %h %h %h %h %h", tnum, word, alu_exp, flags_exp,
                             ir_exp, mask);
            if (fields != 6) begin
                $display("Vector line could not be read: %s", line);
                error_count++;
                continue;
            end
            test_q.push_back(tnum);
            ctrl_q.push_back(word);
            alu_exp_q.push_back(alu_exp);
            flags_exp_q.push_back(flags_exp);
            ir_exp_q.push_back(ir_exp);
            mask_q.push_back(mask);
        end
        $fclose(fd);
        if (ctrl_q.size() == 0) begin
            $display("The vector file holds no vectors");
            error_count++;
        end
    endtask

    // Fields that have no effect under this vector get random values
    function automatic datapath_ctrl_t fill_unused(input datapath_ctrl_t c);
        datapath_ctrl_t r;
        logic [31:0]    rnd;
        r   = c;
        rnd = $urandom;
        if (c.rf.enable == '0) begin
            r.rf.fun    = rnd[1:0];
            r.mux.a_sel = rnd[3:2];
        end
        if (c.arf.enable == '0) begin
            r.arf.fun   = rnd[5:4];
            r.mux.b_sel = rnd[7:6];
        end
        if (!c.ir.enable) begin
            r.ir.lh  = rnd[8];
            r.ir.fun = rnd[10:9];
        end
        if (c.mem.cs) begin
            r.mem.wr = rnd[11];
        end
        return r;
    endfunction

    ////////////////////
    // Stimulus and checks
    ////////////////////

    initial begin
        int errors_at_start;
        clk            = 1'b0;
        rst_n          = 1'b0;
        ctrl           = '0;
        check_count    = 0;
        error_count    = 0;
        errors_at_start = 0;
        vectors_loaded = 1'b0;
        void'($urandom(32'h34b2_9d27));
        load_vectors();
        vectors_loaded = 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < ctrl_q.size(); i++) begin
            if (i == 0 || test_q[i] != test_q[i - 1]) begin
                errors_at_start = error_count;
            end
            ctrl <= fill_unused(ctrl_q[i]);
            // Outputs settle by the falling edge
            @(negedge clk);
            if (mask_q[i][0]) begin
                compare_value("alu_out", 16'(alu_out), 16'(alu_exp_q[i]));
            end
            if (mask_q[i][1]) begin
                compare_value("flags", 16'(alu_flags), 16'(flags_exp_q[i]));
            end
            if (mask_q[i][2]) begin
                compare_value("ir_out", 16'(ir_out), 16'(ir_exp_q[i]));
            end
            if (i == ctrl_q.size() - 1 || test_q[i + 1] != test_q[i]) begin
                $display("test %0d finished with %0d errors", test_q[i],
                         error_count - errors_at_start);
            end
            @(posedge clk);
        end
        // Failed bound assertions count as errors too
        error_count += u_datapath_top.u_datapath_props.fail_count;
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        wait (vectors_loaded);
        #((ctrl_q.size() + 20) * clk_period);
        $display("Run timed out before all vectors were applied");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/datapath_input.txt
# test ctrl(hex, 41 bits) alu_out flags(z c n v) ir_out mask(bit0 alu, bit1 flags, bit2 ir)
# flags and ir_out are the values left by the edges before the line is applied
1 02000000001 00 0 0000 7
1 02000000801 00 8 0000 7
2 00202001001 ff 8 0000 3
2 00602000001 ff 2 0000 3
2 00402000001 00 2 0000 3
2 00002000001 ff 8 0000 3
2 00604000001 00 2 0000 3
3 00202001001 ff 8 0000 3
3 00202006001 7f 2 0000 3
3 00a08002001 80 4 0000 3
3 08800002801 7f 3 0000 3
3 08800003001 00 5 0000 3
3 00800003001 7f d 0000 3
4 04000007801 80 4 0000 3
4 08000007801 c0 6 0000 3
4 08000006801 00 2 0000 3
4 08000007801 40 9 0000 3
4 08000005801 00 1 0000 3
4 08000007001 c0 d 0000 3
4 01000005001 ff 5 0000 3
4 01000003801 00 7 0000 3
5 00000088001 7f d 0000 7
5 08000000002 80 5 0000 7
5 00000000480 7f 7 0000 7
5 00000000002 7f 5 0080 7
5 00000000680 7f 5 0080 7
6 00000000005 7f 5 7f80 7
6 00800002005 80 5 7f80 7
6 00000800005 00 3 7f80 7

// File: files.f
+incdir+common
common/datapath_pkg.sv
register_bank/function_register.sv
register_bank/register_bank.sv
src/instruction_register.sv
src/data_memory.sv
alu/alu_core.sv
alu/alu_flags.sv
src/datapath_top.sv
verification/datapath_props.sv
verification/datapath_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module datapath_tb -f files.f
	./obj_dir/Vdatapath_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Test FAILED" sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
